//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := i2c_master_tb
FILELIST := compile.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, pass if the log holds the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- compile.f
source/i2c_reg_pkg.sv
source/i2c_bus_pkg.sv
source/i2c_regs.sv
source/i2c_byte_ctrl.sv
source/i2c_bit_engine.sv
source/i2c_master_top.sv
verification/i2c_master_checker.sv
verification/i2c_master_tb.sv

//--- source/i2c_bit_engine.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_bit_engine (
    input  wire                           i_sysclk,
    input  wire                           i_reset_n,
    input  wire                           i_enable,
    input  wire [i2c_reg_pkg::DIV_W-1:0]  i_divider,
    input  wire                           i_go,
    input  wire i2c_bus_pkg::bit_cmd_e    i_cmd,
    input  wire                           i_tx,
    output logic                          o_done,
    output logic                          o_rx,
    output logic                          o_al,
    output logic                          o_bus_busy,
    input  wire                           i_scl,
    output logic                          o_scl_oe,
    input  wire                           i_sda,
    output logic                          o_sda_oe
);

    logic [i2c_reg_pkg::DIV_W-1:0] quarter;
    logic [i2c_reg_pkg::DIV_W-1:0] cnt;
    logic [1:0]                    phase;
    logic                          busy;
    logic                          tx;
    logic                          stall;
    logic                          sda_q;
    logic                          scl_q;
    i2c_bus_pkg::bit_cmd_e         cmd;

    // {scl_oe, sda_oe} for each quarter, oe high pulls the line low
    function automatic logic [1:0] drive_for(input i2c_bus_pkg::bit_cmd_e c,
                                             input logic [1:0] p,
                                             input logic b);
        case (c)
            i2c_bus_pkg::BIT_START:   return {p == 2'd3, p[1]};
            i2c_bus_pkg::BIT_RESTART: return {p == 2'd0 || p == 2'd3, p[1]};
            i2c_bus_pkg::BIT_STOP:    return {p == 2'd0, p != 2'd3};
            i2c_bus_pkg::BIT_WRITE:   return {p == 2'd0 || p == 2'd3, !b};
            default:                  return {p == 2'd0 || p == 2'd3, 1'b0};
        endcase
    endfunction

    assign quarter = i_divider >> 2;
    assign stall   = busy && !o_scl_oe && !i_scl;   // slave stretching scl
    assign o_done  = i_enable && busy && phase == 2'd3 && cnt == '0 && !stall;

    always_ff @(posedge i_sysclk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            busy <= 1'b0;
            phase <= 2'd0;
            cnt <= '0;
            cmd <= i2c_bus_pkg::BIT_STOP;
            tx <= 1'b1;
            o_scl_oe <= 1'b0;
            o_sda_oe <= 1'b0;
            o_rx <= 1'b1;
            o_al <= 1'b0;
        end else begin
            o_al <= 1'b0;
            if (!i_enable) begin
                busy <= 1'b0;
                o_scl_oe <= 1'b0;
                o_sda_oe <= 1'b0;
            end else if (i_go) begin
                busy <= 1'b1;
                phase <= 2'd0;
                cnt <= quarter - 1'b1;
                cmd <= i_cmd;
                tx <= i_tx;
                {o_scl_oe, o_sda_oe} <= drive_for(i_cmd, 2'd0, i_tx);
            end else if (o_done) begin
                busy <= 1'b0;
            end else if (busy && !stall) begin
                if (cnt != '0) begin
                    cnt <= cnt - 1'b1;
                end else begin
                    if (phase == 2'd1) o_rx <= i_sda;   // middle of scl high
                    if (phase == 2'd1 && cmd == i2c_bus_pkg::BIT_WRITE && tx && !i_sda) begin
                        busy <= 1'b0;
                        o_al <= 1'b1;
                        o_scl_oe <= 1'b0;
                        o_sda_oe <= 1'b0;
                    end else begin
                        phase <= phase + 2'd1;
                        cnt <= quarter - 1'b1;
                        {o_scl_oe, o_sda_oe} <= drive_for(cmd, phase + 2'd1, tx);
                    end
                end
            end
        end
    end

    // start and stop seen on the bus by anyone
    always_ff @(posedge i_sysclk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            sda_q <= 1'b1;
            scl_q <= 1'b1;
            o_bus_busy <= 1'b0;
        end else begin
            sda_q <= i_sda;
            scl_q <= i_scl;
            if (scl_q && i_scl && sda_q && !i_sda)
                o_bus_busy <= 1'b1;
            else if (scl_q && i_scl && !sda_q && i_sda)
                o_bus_busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/i2c_bus_pkg.sv
`default_nettype none

package i2c_bus_pkg;

    // requests from the register block
    typedef enum logic [2:0] {
        BYTE_NONE,
        BYTE_START,
        BYTE_RESTART,
        BYTE_STOP,
        BYTE_WRITE,
        BYTE_READ
    } byte_cmd_e;

    // one scl period each
    typedef enum logic [2:0] {
        BIT_START,
        BIT_RESTART,
        BIT_STOP,
        BIT_WRITE,
        BIT_READ
    } bit_cmd_e;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_START,
        SEQ_STOP,
        SEQ_DATA,
        SEQ_ACK
    } seq_state_e;

endpackage

`default_nettype wire

//--- source/i2c_byte_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_byte_ctrl (
    input  wire                          i_sysclk,
    input  wire                          i_reset_n,
    input  wire                          i_enable,
    input  wire                          i_req,
    input  wire i2c_bus_pkg::byte_cmd_e  i_req_cmd,
    input  wire [7:0]                    i_tx_byte,
    input  wire                          i_txak,
    output logic                         o_done,
    output logic [7:0]                   o_rx_byte,
    output logic                         o_rxack,
    output logic                         o_al,
    output logic                         o_bit_go,
    output i2c_bus_pkg::bit_cmd_e        o_bit_cmd,
    output logic                         o_bit_tx,
    input  wire                          i_bit_done,
    input  wire                          i_bit_rx,
    input  wire                          i_bit_al
);

    i2c_bus_pkg::seq_state_e state;
    logic [7:0] shreg;
    logic [2:0] bit_cnt;
    logic       is_read;
    logic       txak;

    assign o_rx_byte = shreg;

    // next bit is issued in the cycle the previous one ends, so bits run back to back
    always_comb begin
        o_bit_go = 1'b0;
        o_bit_cmd = i2c_bus_pkg::BIT_WRITE;
        o_bit_tx = 1'b1;
        case (state)
            i2c_bus_pkg::SEQ_IDLE: begin
                if (i_enable && i_req) begin
                    o_bit_go = 1'b1;
                    case (i_req_cmd)
                        i2c_bus_pkg::BYTE_START:   o_bit_cmd = i2c_bus_pkg::BIT_START;
                        i2c_bus_pkg::BYTE_RESTART: o_bit_cmd = i2c_bus_pkg::BIT_RESTART;
                        i2c_bus_pkg::BYTE_STOP:    o_bit_cmd = i2c_bus_pkg::BIT_STOP;
                        i2c_bus_pkg::BYTE_WRITE:   o_bit_tx = i_tx_byte[7];   // msb first
                        i2c_bus_pkg::BYTE_READ:    o_bit_cmd = i2c_bus_pkg::BIT_READ;
                        default:                   o_bit_go = 1'b0;
                    endcase
                end
            end
            i2c_bus_pkg::SEQ_DATA: begin
                if (i_bit_done && !i_bit_al) begin
                    o_bit_go = 1'b1;
                    if (bit_cnt == 3'd7) begin        // ack slot, direction flips
                        o_bit_cmd = is_read ? i2c_bus_pkg::BIT_WRITE : i2c_bus_pkg::BIT_READ;
                        o_bit_tx = txak;
                    end else begin
                        o_bit_cmd = is_read ? i2c_bus_pkg::BIT_READ : i2c_bus_pkg::BIT_WRITE;
                        o_bit_tx = shreg[6];
                    end
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_sysclk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            state <= i2c_bus_pkg::SEQ_IDLE;
            shreg <= 8'h00;
            bit_cnt <= 3'd0;
            is_read <= 1'b0;
            txak <= 1'b0;
            o_done <= 1'b0;
            o_rxack <= 1'b1;
            o_al <= 1'b0;
        end else begin
            o_done <= 1'b0;
            o_al <= 1'b0;
            if (!i_enable) begin
                state <= i2c_bus_pkg::SEQ_IDLE;
            end else if (i_bit_al) begin     // lost the bus, give up the byte
                state <= i2c_bus_pkg::SEQ_IDLE;
                o_al <= 1'b1;
            end else begin
                case (state)
                    i2c_bus_pkg::SEQ_IDLE: begin
                        if (o_bit_go) begin
                            bit_cnt <= 3'd0;
                            shreg <= i_tx_byte;
                            is_read <= i_req_cmd == i2c_bus_pkg::BYTE_READ;
                            txak <= i_txak;
                            case (i_req_cmd)
                                i2c_bus_pkg::BYTE_START,
                                i2c_bus_pkg::BYTE_RESTART: state <= i2c_bus_pkg::SEQ_START;
                                i2c_bus_pkg::BYTE_STOP:    state <= i2c_bus_pkg::SEQ_STOP;
                                default:                   state <= i2c_bus_pkg::SEQ_DATA;
                            endcase
                        end
                    end
                    i2c_bus_pkg::SEQ_START,
                    i2c_bus_pkg::SEQ_STOP: begin
                        if (i_bit_done) begin
                            o_done <= 1'b1;
                            state <= i2c_bus_pkg::SEQ_IDLE;
                        end
                    end
                    i2c_bus_pkg::SEQ_DATA: begin
                        if (i_bit_done) begin
                            shreg <= {shreg[6:0], i_bit_rx};
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7) state <= i2c_bus_pkg::SEQ_ACK;
                        end
                    end
                    i2c_bus_pkg::SEQ_ACK: begin
                        if (i_bit_done) begin
                            o_done <= 1'b1;
                            o_rxack <= i_bit_rx;
                            state <= i2c_bus_pkg::SEQ_IDLE;
                        end
                    end
                    default: state <= i2c_bus_pkg::SEQ_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- source/i2c_master_top.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_master_top (
    input  wire        i_sysclk,
    input  wire        i_reset_n,
    input  wire        i_wr_en,
    input  wire [4:0]  i_wr_addr,
    input  wire [7:0]  i_wr_data,
    input  wire        i_rd_en,
    input  wire [4:0]  i_rd_addr,
    output logic [7:0] o_rd_data,
    output logic       o_rd_valid,
    output logic       o_irq,
    input  wire        i_scl,
    output logic       o_scl_oe,   // high pulls scl low
    input  wire        i_sda,
    output logic       o_sda_oe
);

    logic                          enable;
    logic [i2c_reg_pkg::DIV_W-1:0] divider;
    logic                          req;
    i2c_bus_pkg::byte_cmd_e        req_cmd;
    logic [7:0]                    tx_byte;
    logic                          txak;
    logic                          done;
    logic [7:0]                    rx_byte;
    logic                          rxack;
    logic                          al;
    logic                          bus_busy;
    logic                          bit_go;
    i2c_bus_pkg::bit_cmd_e         bit_cmd;
    logic                          bit_tx;
    logic                          bit_done;
    logic                          bit_rx;
    logic                          bit_al;

    i2c_regs u_regs (
        .i_sysclk   (i_sysclk),
        .i_reset_n  (i_reset_n),
        .i_wr_en    (i_wr_en),
        .i_wr_addr  (i_wr_addr),
        .i_wr_data  (i_wr_data),
        .i_rd_en    (i_rd_en),
        .i_rd_addr  (i_rd_addr),
        .o_rd_data  (o_rd_data),
        .o_rd_valid (o_rd_valid),
        .o_irq      (o_irq),
        .o_enable   (enable),
        .o_divider  (divider),
        .o_req      (req),
        .o_req_cmd  (req_cmd),
        .o_tx_byte  (tx_byte),
        .o_txak     (txak),
        .i_done     (done),
        .i_rx_byte  (rx_byte),
        .i_rxack    (rxack),
        .i_al       (al),
        .i_bus_busy (bus_busy)
    );

    i2c_byte_ctrl u_byte_ctrl (
        .i_sysclk   (i_sysclk),
        .i_reset_n  (i_reset_n),
        .i_enable   (enable),
        .i_req      (req),
        .i_req_cmd  (req_cmd),
        .i_tx_byte  (tx_byte),
        .i_txak     (txak),
        .o_done     (done),
        .o_rx_byte  (rx_byte),
        .o_rxack    (rxack),
        .o_al       (al),
        .o_bit_go   (bit_go),
        .o_bit_cmd  (bit_cmd),
        .o_bit_tx   (bit_tx),
        .i_bit_done (bit_done),
        .i_bit_rx   (bit_rx),
        .i_bit_al   (bit_al)
    );

    i2c_bit_engine u_bit_engine (
        .i_sysclk   (i_sysclk),
        .i_reset_n  (i_reset_n),
        .i_enable   (enable),
        .i_divider  (divider),
        .i_go       (bit_go),
        .i_cmd      (bit_cmd),
        .i_tx       (bit_tx),
        .o_done     (bit_done),
        .o_rx       (bit_rx),
        .o_al       (bit_al),
        .o_bus_busy (bus_busy),
        .i_scl      (i_scl),
        .o_scl_oe   (o_scl_oe),
        .i_sda      (i_sda),
        .o_sda_oe   (o_sda_oe)
    );

endmodule

`default_nettype wire

//--- source/i2c_reg_pkg.sv
`default_nettype none

package i2c_reg_pkg;

    // word offsets, host address bits 4 to 2
    localparam logic [2:0] REG_ADR = 3'd0;
    localparam logic [2:0] REG_FDR = 3'd1;
    localparam logic [2:0] REG_CR  = 3'd2;
    localparam logic [2:0] REG_SR  = 3'd3;
    localparam logic [2:0] REG_DR  = 3'd4;

    localparam int CR_MEN  = 7;
    localparam int CR_MIEN = 6;
    localparam int CR_MSTA = 5;
    localparam int CR_MTX  = 4;
    localparam int CR_TXAK = 3;
    localparam int CR_RSTA = 2;

    localparam int SR_MCF  = 7;
    localparam int SR_MBB  = 5;
    localparam int SR_MAL  = 4;
    localparam int SR_MIF  = 1;
    localparam int SR_RXAK = 0;

    localparam logic [7:0] SR_RESET = 8'h81;   // mcf and rxak set

    localparam int DIV_W = 16;

    // scl period in sysclk cycles, indexed by fdr[5:0]
    localparam logic [DIV_W-1:0] FDR_TABLE [64] = '{
        384,   416,   480,   576,   640,   704,   832,   1024,
        1152,  1280,  1536,  1920,  2304,  2560,  3072,  3840,
        4608,  5120,  6144,  7680,  9216,  10240, 12288, 15360,
        18432, 20480, 24576, 30720, 36864, 40960, 49152, 61440,
        256,   288,   320,   352,   384,   448,   512,   576,
        640,   768,   896,   1024,  1280,  1536,  1792,  2048,
        2560,  3072,  3584,  4096,  5120,  6144,  7168,  8192,
        10240, 12288, 14336, 16384, 20480, 24576, 28672, 32768
    };

    function automatic logic [DIV_W-1:0] fdr_divider(input logic [7:0] fdr);
        return FDR_TABLE[fdr[5:0]];
    endfunction

endpackage

`default_nettype wire

//--- source/i2c_regs.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_regs (
    input  wire                           i_sysclk,
    input  wire                           i_reset_n,
    input  wire                           i_wr_en,
    input  wire [4:0]                     i_wr_addr,
    input  wire [7:0]                     i_wr_data,
    input  wire                           i_rd_en,
    input  wire [4:0]                     i_rd_addr,
    output logic [7:0]                    o_rd_data,
    output logic                          o_rd_valid,
    output logic                          o_irq,
    output logic                          o_enable,
    output logic [i2c_reg_pkg::DIV_W-1:0] o_divider,
    output logic                          o_req,
    output i2c_bus_pkg::byte_cmd_e        o_req_cmd,
    output logic [7:0]                    o_tx_byte,
    output logic                          o_txak,
    input  wire                           i_done,
    input  wire [7:0]                     i_rx_byte,
    input  wire                           i_rxack,
    input  wire                           i_al,
    input  wire                           i_bus_busy
);

    logic [7:0] adr;
    logic [7:0] fdr;
    logic [7:0] cr;
    logic [7:0] dr;
    logic [7:0] sr;
    logic [7:0] rd_mux;
    logic       mcf;
    logic       mal;
    logic       mif;
    logic       rxak;
    logic       active;     // request handed to sequencer, not yet done
    logic       dat_pend;
    i2c_bus_pkg::byte_cmd_e ctl_cmd;   // pending start, restart or stop
    i2c_bus_pkg::byte_cmd_e dat_cmd;

    assign o_enable  = cr[i2c_reg_pkg::CR_MEN];
    assign o_txak    = cr[i2c_reg_pkg::CR_TXAK];
    assign o_tx_byte = dr;
    assign o_irq     = cr[i2c_reg_pkg::CR_MIEN] & (mif | mal);

    always_comb begin
        sr = 8'h00;
        sr[i2c_reg_pkg::SR_MCF]  = mcf;
        sr[i2c_reg_pkg::SR_MBB]  = i_bus_busy;
        sr[i2c_reg_pkg::SR_MAL]  = mal;
        sr[i2c_reg_pkg::SR_MIF]  = mif;
        sr[i2c_reg_pkg::SR_RXAK] = rxak;
        case (i_rd_addr[4:2])
            i2c_reg_pkg::REG_ADR: rd_mux = adr;
            i2c_reg_pkg::REG_FDR: rd_mux = fdr;
            i2c_reg_pkg::REG_CR:  rd_mux = cr;
            i2c_reg_pkg::REG_SR:  rd_mux = sr;
            i2c_reg_pkg::REG_DR:  rd_mux = dr;
            default:              rd_mux = 8'hFF;
        endcase
    end

    always_ff @(posedge i_sysclk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            adr <= 8'h00;
            fdr <= 8'h00;
            cr <= 8'h00;
            dr <= 8'h00;
            mcf <= i2c_reg_pkg::SR_RESET[i2c_reg_pkg::SR_MCF];
            mal <= i2c_reg_pkg::SR_RESET[i2c_reg_pkg::SR_MAL];
            mif <= i2c_reg_pkg::SR_RESET[i2c_reg_pkg::SR_MIF];
            rxak <= i2c_reg_pkg::SR_RESET[i2c_reg_pkg::SR_RXAK];
            active <= 1'b0;
            dat_pend <= 1'b0;
            ctl_cmd <= i2c_bus_pkg::BYTE_NONE;
            dat_cmd <= i2c_bus_pkg::BYTE_WRITE;
            o_req <= 1'b0;
            o_req_cmd <= i2c_bus_pkg::BYTE_NONE;
            o_rd_data <= 8'h00;
            o_rd_valid <= 1'b0;
            o_divider <= i2c_reg_pkg::fdr_divider(8'h00);
        end else begin
            o_req <= 1'b0;
            o_rd_valid <= i_rd_en;
            o_divider <= i2c_reg_pkg::fdr_divider(fdr);
            if (i_rd_en) o_rd_data <= rd_mux;

            if (!cr[i2c_reg_pkg::CR_MEN]) begin     // disabled, drop everything
                ctl_cmd <= i2c_bus_pkg::BYTE_NONE;
                dat_pend <= 1'b0;
                active <= 1'b0;
                mcf <= 1'b1;
            end else if (!active) begin              // control requests go first
                if (ctl_cmd != i2c_bus_pkg::BYTE_NONE) begin
                    o_req <= 1'b1;
                    o_req_cmd <= ctl_cmd;
                    ctl_cmd <= i2c_bus_pkg::BYTE_NONE;
                    active <= 1'b1;
                end else if (dat_pend) begin
                    o_req <= 1'b1;
                    o_req_cmd <= dat_cmd;
                    dat_pend <= 1'b0;
                    active <= 1'b1;
                end
            end
            if (i_done || i_al) active <= 1'b0;

            if (i_wr_en) begin
                case (i_wr_addr[4:2])
                    i2c_reg_pkg::REG_ADR: adr <= i_wr_data;
                    i2c_reg_pkg::REG_FDR: fdr <= i_wr_data;
                    i2c_reg_pkg::REG_CR: begin
                        cr <= i_wr_data;
                        cr[i2c_reg_pkg::CR_RSTA] <= 1'b0;   // self clearing
                        if (mcf && i_wr_data[i2c_reg_pkg::CR_MEN]) begin
                            if (i_wr_data[i2c_reg_pkg::CR_RSTA])
                                ctl_cmd <= i2c_bus_pkg::BYTE_RESTART;
                            else if (i_wr_data[i2c_reg_pkg::CR_MSTA] && !cr[i2c_reg_pkg::CR_MSTA])
                                ctl_cmd <= i2c_bus_pkg::BYTE_START;
                            else if (!i_wr_data[i2c_reg_pkg::CR_MSTA] && cr[i2c_reg_pkg::CR_MSTA])
                                ctl_cmd <= i2c_bus_pkg::BYTE_STOP;
                        end
                    end
                    i2c_reg_pkg::REG_SR: begin
                        if (!i_wr_data[i2c_reg_pkg::SR_MIF]) mif <= 1'b0;
                        if (!i_wr_data[i2c_reg_pkg::SR_MAL]) mal <= 1'b0;
                    end
                    i2c_reg_pkg::REG_DR: begin
                        dr <= i_wr_data;
                        if (cr[i2c_reg_pkg::CR_MTX] && mcf) begin
                            dat_pend <= 1'b1;
                            dat_cmd <= i2c_bus_pkg::BYTE_WRITE;
                            mcf <= 1'b0;
                            mif <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end

            // dr read returns the old byte and fetches the next one
            if (i_rd_en && i_rd_addr[4:2] == i2c_reg_pkg::REG_DR && !cr[i2c_reg_pkg::CR_MTX]
                    && i_bus_busy && mcf) begin
                dat_pend <= 1'b1;
                dat_cmd <= i2c_bus_pkg::BYTE_READ;
                mcf <= 1'b0;
                mif <= 1'b0;
            end

            if (i_done) begin
                mcf <= 1'b1;
                if (o_req_cmd == i2c_bus_pkg::BYTE_WRITE) begin
                    mif <= 1'b1;
                    rxak <= i_rxack;
                end
                if (o_req_cmd == i2c_bus_pkg::BYTE_READ) begin
                    mif <= 1'b1;
                    dr <= i_rx_byte;
                end
            end
            if (i_al) begin
                mal <= 1'b1;
                mif <= 1'b1;
                mcf <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/i2c_master_checker.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_master_checker (
    input wire i_sysclk,
    input wire i_reset_n,
    input wire i_rd_en,
    input wire o_rd_valid,
    input wire o_irq,
    input wire i_scl,
    input wire o_scl_oe,
    input wire o_sda_oe
);

    rd_valid_follows_read: assert property (@(posedge i_sysclk) disable iff (!i_reset_n)
        o_rd_valid == $past(i_rd_en))
        else $error("o_rd_valid does not follow i_rd_en by one cycle");

    // sda drive moves only while the scl line holds its level
    sda_moves_on_steady_scl: assert property (@(posedge i_sysclk) disable iff (!i_reset_n)
        $changed(o_sda_oe) |-> $stable(i_scl))
        else $error("o_sda_oe changed in the same cycle as scl");

    irq_low_after_reset: assert property (@(posedge i_sysclk)
        $past(i_reset_n) == 1'b0 |-> !o_irq)
        else $error("o_irq high in the cycle after reset");

    bus_released_in_reset: assert property (@(posedge i_sysclk)
        !i_reset_n |-> (!o_scl_oe && !o_sda_oe))
        else $error("bus driven during reset");

endmodule

bind i2c_master_top i2c_master_checker u_checker (
    .i_sysclk   (i_sysclk),
    .i_reset_n  (i_reset_n),
    .i_rd_en    (i_rd_en),
    .o_rd_valid (o_rd_valid),
    .o_irq      (o_irq),
    .i_scl      (i_scl),
    .o_scl_oe   (o_scl_oe),
    .o_sda_oe   (o_sda_oe)
);

`default_nettype wire

//--- verification/i2c_master_tb.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_master_tb;

    logic        sysclk;
    logic        reset_n;
    logic        wr_en;
    logic [4:0]  wr_addr;
    logic [7:0]  wr_data;
    logic        rd_en;
    logic [4:0]  rd_addr;
    wire  [7:0]  rd_data;
    wire         rd_valid;
    wire         irq;
    wire         scl_oe;
    wire         sda_oe;
    logic        slv_sda_low;
    wire         scl = !scl_oe;                  // pull-up, only the master drives scl
    wire         sda = !(sda_oe || slv_sda_low);  // wired-AND

    logic [7:0]  t_op [$];
    logic [15:0] t_a [$];
    logic [15:0] t_b [$];
    logic [15:0] t_c [$];
    logic [8:0]  rx_exp [$];   // {ack to give, expected byte}
    logic [8:0]  tx_src [$];   // {expected master ack, byte to send}
    logic [8:0]  cur_tx;
    logic [8:0]  cur_rx;
    logic [6:0]  slv_addr;
    logic        slv_force_al;
    logic [15:0] exp_period;
    logic        scl_q;
    logic        sda_q;
    logic        active;
    logic        addr_phase;
    logic        rd_dir;
    logic        sending;
    logic        master_nak;
    logic        al_pending;
    logic [3:0]  cnt;
    logic [7:0]  shreg;
    logic [15:0] hold;
    int unsigned cycles;
    int unsigned last_rise;
    int unsigned limit;

    i2c_master_top u_dut (
        .i_sysclk   (sysclk),
        .i_reset_n  (reset_n),
        .i_wr_en    (wr_en),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (wr_data),
        .i_rd_en    (rd_en),
        .i_rd_addr  (rd_addr),
        .o_rd_data  (rd_data),
        .o_rd_valid (rd_valid),
        .o_irq      (irq),
        .i_scl      (scl),
        .o_scl_oe   (scl_oe),
        .i_sda      (sda),
        .o_sda_oe   (sda_oe)
    );

    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;
    end

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic fail_plain(input string msg);
        $display("ERROR: %s", msg);
        stop_run();
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic host_write(input logic [4:0] a, input logic [7:0] d);
        @(posedge sysclk);
        wr_en <= 1'b1;
        wr_addr <= a;
        wr_data <= d;
        @(posedge sysclk);
        wr_en <= 1'b0;
    endtask

    task automatic host_read(input logic [4:0] a, output logic [7:0] d);
        @(posedge sysclk);
        rd_en <= 1'b1;
        rd_addr <= a;
        @(posedge sysclk);
        rd_en <= 1'b0;
        @(negedge sysclk);
        assert (rd_valid) else fail_plain("read data valid did not follow the read strobe");
        d = rd_data;
    endtask

    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit)
            fail_plain($sformatf("run did not finish within %0d cycles", limit));
    end

    // bus slave, sees the lines one sysclk late
    always @(posedge sysclk) begin
        scl_q <= scl;
        sda_q <= sda;
        if (hold != 0) begin
            hold <= hold - 1'b1;
            if (hold == 1) slv_sda_low <= 1'b0;   // release with scl high, looks like a stop
        end
        if (scl_q && scl && sda_q && !sda) begin           // start
            active <= !slv_force_al;
            al_pending <= slv_force_al;
            addr_phase <= 1'b1;
            sending <= 1'b0;
            cnt <= 4'd0;
            if (slv_force_al) slv_sda_low <= 1'b1;
        end else if (scl_q && scl && !sda_q && sda) begin  // stop
            active <= 1'b0;
        end else if (!scl_q && scl) begin
            last_rise <= cycles;
            if (al_pending) begin
                hold <= exp_period / 2;
                al_pending <= 1'b0;
            end
            if (active && cnt != 0) check_eq("scl period", cycles - last_rise, exp_period);
            if (active && cnt < 8 && !sending) shreg <= {shreg[6:0], sda};
            if (active && cnt == 8 && sending) begin
                check_eq("master ack", sda, cur_tx[8]);
                master_nak <= sda;
            end
            cnt <= cnt + 1'b1;
        end else if (scl_q && !scl && active) begin
            if (cnt == 8 && !sending) begin
                if (addr_phase) begin
                    check_eq("slave address", shreg[7:1], slv_addr);
                    rd_dir <= shreg[0];
                    slv_sda_low <= 1'b1;
                end else begin
                    assert (rx_exp.size() != 0) else fail_plain("slave got an unexpected byte");
                    cur_rx = rx_exp.pop_front();
                    check_eq("slave rx byte", shreg, cur_rx[7:0]);
                    slv_sda_low <= !cur_rx[8];
                end
            end else if (cnt == 8) begin
                slv_sda_low <= 1'b0;   // master's ack slot
            end else if (cnt == 9) begin
                cnt <= 4'd0;
                addr_phase <= 1'b0;
                if ((addr_phase && rd_dir) || (!addr_phase && sending && !master_nak)) begin
                    assert (tx_src.size() != 0) else fail_plain("slave has no byte to send");
                    cur_tx = tx_src.pop_front();
                    slv_sda_low <= !cur_tx[7];
                    sending <= 1'b1;
                end else begin
                    slv_sda_low <= 1'b0;
                    sending <= 1'b0;
                end
            end else if (sending) begin
                slv_sda_low <= !cur_tx[7 - cnt];
            end
        end
    end

    initial begin
        int          fd;
        int          code;
        int unsigned maxp;
        logic [7:0]  op;
        logic [7:0]  rd;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        logic [8*120-1:0] skip;
        void'($urandom(59));
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_en = 1'b0;
        rd_addr = '0;
        reset_n = 1'b0;
        slv_sda_low = 1'b0;
        slv_addr = '0;
        slv_force_al = 1'b0;
        exp_period = '0;
        {scl_q, sda_q} = 2'b11;
        {active, addr_phase, rd_dir, sending, master_nak, al_pending} = '0;
        cnt = '0;
        shreg = '0;
        hold = '0;
        cycles = 0;
        last_rise = 0;
        limit = 0;
        maxp = 0;
        fd = $fopen("verification/i2c_master_trace.txt", "r");
        assert (fd != 0) else fail_plain("cannot open the trace file");
        while ($fscanf(fd, " %c", op) == 1) begin
            if (op == "#") begin
                code = $fgets(skip, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h", a, b, c);
                t_op.push_back(op);
                t_a.push_back(a);
                t_b.push_back(b);
                t_c.push_back(c);
                if (op == "C" && a > maxp) maxp = a;
            end
        end
        $fclose(fd);
        limit = t_op.size() * 12 * maxp;
        repeat (10) @(posedge sysclk);
        reset_n <= 1'b1;
        foreach (t_op[i]) begin
            repeat ($urandom % 4) @(posedge sysclk);
            case (t_op[i])
                "W": host_write(t_a[i][4:0], t_b[i][7:0]);
                "R": begin
                    host_read(t_a[i][4:0], rd);
                    check_eq("o_rd_data", rd, t_b[i]);
                end
                "P": begin
                    host_read(t_a[i][4:0], rd);
                    while ((rd & t_b[i][7:0]) != t_c[i][7:0]) host_read(t_a[i][4:0], rd);
                end
                "I": begin
                    @(negedge sysclk);
                    while (!irq) @(negedge sysclk);
                end
                "Q": begin
                    @(negedge sysclk);
                    check_eq("o_irq", irq, t_a[i]);
                end
                "S": begin
                    slv_addr = t_a[i][6:0];
                    slv_force_al = t_b[i][0];
                end
                "E": rx_exp.push_back({t_b[i][0], t_a[i][7:0]});
                "T": tx_src.push_back({t_b[i][0], t_a[i][7:0]});
                "C": exp_period = t_a[i];
                default: fail_plain("unknown operation in the trace");
            endcase
        end
        check_eq("slave rx bytes left", rx_exp.size(), 0);
        check_eq("slave tx bytes left", tx_src.size(), 0);
        repeat (10) @(posedge sysclk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/i2c_master_trace.txt
# op a b c in hex: W addr data, R addr expect, P addr mask expect, I wait irq, Q irq
# S slave_addr force_al, E rx_byte ack_to_give, T tx_byte master_ack, C scl_period
R 08 00 0
R 04 00 0
R 0c 81 0
R 10 00 0
R 1c ff 0
C 100 0 0
W 04 20 0
S 50 0 0
E 3c 0 0
E c3 1 0
W 08 f0 0
W 10 a0 0
I 0 0 0
R 0c a2 0
W 10 3c 0
I 0 0 0
R 0c a2 0
W 10 c3 0
I 0 0 0
R 0c a3 0
W 08 d0 0
P 0c 20 00
W 0c 00 0
R 0c 81 0
C 120 0 0
W 04 21 0
S 50 0 0
T 5a 0 0
T 96 1 0
W 08 f0 0
W 10 a1 0
I 0 0 0
R 0c a2 0
W 08 e0 0
R 10 a1 0
I 0 0 0
W 08 e8 0
R 10 5a 0
I 0 0 0
W 08 c8 0
P 0c 20 00
R 10 96 0
W 0c 00 0
S 50 1 0
W 08 b0 0
W 10 a0 0
P 0c 10 10
Q 0 0 0
P 0c 20 00
R 0c 92 0
W 08 f0 0
Q 1 0 0
W 0c 00 0
Q 0 0 0
R 0c 80 0
W 08 00 0
